/* video_pkg.sv */
package video_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Pixel format

    // 4:4:4 colour, red in the top nibble
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } pixel_t;

    localparam pixel_t PIXEL_BLACK = '0;

    ////////////////////////////////////////////////////////////////////////////
    // Drawing commands

    typedef enum logic [1:0] {
        PAT_SOLID    = 2'd0,
        PAT_CHECKER  = 2'd1,
        PAT_GRADIENT = 2'd2,
        PAT_BORDER   = 2'd3
    } pattern_e;

    // Latched by the drawer at the start of each pass
    typedef struct packed {
        pattern_e pattern;
        pixel_t   colour;
    } draw_cmd_t;

    ////////////////////////////////////////////////////////////////////////////
    // Display output

    // Syncs are active low
    typedef struct packed {
        logic   hsync;
        logic   vsync;
        pixel_t colour;
    } vga_out_t;

endpackage

/* frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer #(
    parameter int DEPTH = 192
) (
    input  logic                     clk_display,
    input  logic                     rstn_display,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  video_pkg::pixel_t        wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output video_pkg::pixel_t        rd_data
);

    video_pkg::pixel_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk_display) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            rd_data <= video_pkg::PIXEL_BLACK;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* display_scanout.sv */
`timescale 1ns/1ps

module display_scanout #(
    parameter int BUF_WIDTH  = 16,
    parameter int BUF_HEIGHT = 12,
    parameter int SCALE_LOG2 = 1,
    parameter int H_FRONT    = 2,
    parameter int H_SYNC     = 4,
    parameter int H_BACK     = 2,
    parameter int V_FRONT    = 1,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 1
) (
    input  logic                                     clk_display,
    input  logic                                     rstn_display,
    input  video_pkg::pixel_t                        rd_data,
    output logic [$clog2(BUF_WIDTH*BUF_HEIGHT)-1:0] rd_addr,
    output video_pkg::vga_out_t                      vga
);

    localparam int H_ACTIVE = BUF_WIDTH << SCALE_LOG2;
    localparam int V_ACTIVE = BUF_HEIGHT << SCALE_LOG2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HC_W     = $clog2(H_TOTAL);
    localparam int VC_W     = $clog2(V_TOTAL);
    localparam int ADDR_W   = $clog2(BUF_WIDTH * BUF_HEIGHT);
    localparam int BX_W     = $clog2(BUF_WIDTH);
    localparam int BY_W     = $clog2(BUF_HEIGHT);

    logic [HC_W-1:0] hcnt;
    logic [VC_W-1:0] vcnt;
    logic [BX_W-1:0] buf_x;
    logic [BY_W-1:0] buf_y;
    logic            active;
    logic            hsync_n;
    logic            vsync_n;

    // Flags delayed by one cycle to line up with rd_data
    logic            active_d;
    logic            hsync_d;
    logic            vsync_d;

    ////////////////////////////////////////////////////////////////////////////
    // Raster counters

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            hcnt <= '0;
            vcnt <= '0;
        end else begin
            if (hcnt == HC_W'(H_TOTAL - 1)) begin
                hcnt <= '0;
                if (vcnt == VC_W'(V_TOTAL - 1)) begin
                    vcnt <= '0;
                end else begin
                    vcnt <= vcnt + 1'b1;
                end
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Region decode and buffer address

    always_comb begin
        active  = (hcnt < HC_W'(H_ACTIVE)) && (vcnt < VC_W'(V_ACTIVE));
        hsync_n = !((hcnt >= HC_W'(H_ACTIVE + H_FRONT)) &&
                    (hcnt < HC_W'(H_ACTIVE + H_FRONT + H_SYNC)));
        vsync_n = !((vcnt >= VC_W'(V_ACTIVE + V_FRONT)) &&
                    (vcnt < VC_W'(V_ACTIVE + V_FRONT + V_SYNC)));
    end

    // Drop the replication bits to get buffer coordinates
    assign buf_x = hcnt[SCALE_LOG2 +: BX_W];
    assign buf_y = vcnt[SCALE_LOG2 +: BY_W];

    assign rd_addr = active ? ADDR_W'(buf_y * BUF_WIDTH + buf_x) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Output pipeline

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
            vga      <= '{hsync: 1'b1, vsync: 1'b1, colour: video_pkg::PIXEL_BLACK};
        end else begin
            active_d   <= active;
            hsync_d    <= hsync_n;
            vsync_d    <= vsync_n;
            vga.hsync  <= hsync_d;
            vga.vsync  <= vsync_d;
            // Black during blanking
            vga.colour <= active_d ? rd_data : video_pkg::PIXEL_BLACK;
        end
    end

    a_sync_known: assert property (
        @(posedge clk_display) disable iff (!rstn_display)
        !$isunknown({vga.hsync, vga.vsync})
    );

endmodule

/* pattern_drawer.sv */
`timescale 1ns/1ps

module pattern_drawer #(
    parameter int BUF_WIDTH  = 16,
    parameter int BUF_HEIGHT = 12
) (
    input  logic                                     clk_display,
    input  logic                                     rstn_display,
    input  video_pkg::draw_cmd_t                     draw_cmd,
    input  logic                                     draw_start,
    input  logic                                     draw_ack,
    output logic                                     wr_en,
    output logic [$clog2(BUF_WIDTH*BUF_HEIGHT)-1:0] wr_addr,
    output video_pkg::pixel_t                        wr_data,
    output logic                                     frame_done
);

    localparam int DEPTH  = BUF_WIDTH * BUF_HEIGHT;
    localparam int ADDR_W = $clog2(DEPTH);
    localparam int BX_W   = $clog2(BUF_WIDTH);
    localparam int BY_W   = $clog2(BUF_HEIGHT);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DRAW,
        ST_DONE
    } state_e;

    state_e               state;
    logic [BX_W-1:0]      bx;
    logic [BY_W-1:0]      by;
    video_pkg::draw_cmd_t cmd_q;
    logic                 last_px;
    logic                 on_edge;

    assign last_px = (bx == BX_W'(BUF_WIDTH - 1)) && (by == BY_W'(BUF_HEIGHT - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Pass sequencing

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            state <= ST_IDLE;
            bx    <= '0;
            by    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (draw_start) begin
                        state <= ST_DRAW;
                        bx    <= '0;
                        by    <= '0;
                    end
                end
                ST_DRAW: begin
                    if (last_px) begin
                        state <= ST_DONE;
                    end else if (bx == BX_W'(BUF_WIDTH - 1)) begin
                        bx <= '0;
                        by <= by + 1'b1;
                    end else begin
                        bx <= bx + 1'b1;
                    end
                end
                // Hold frame_done until the swap is taken
                ST_DONE: begin
                    if (draw_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command register, loaded once per pass
    always_ff @(posedge clk_display) begin
        if (draw_start) begin
            cmd_q <= draw_cmd;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pixel generation

    assign on_edge = (bx == '0) || (bx == BX_W'(BUF_WIDTH - 1)) ||
                     (by == '0) || (by == BY_W'(BUF_HEIGHT - 1));

    always_comb begin
        case (cmd_q.pattern)
            video_pkg::PAT_SOLID:
                wr_data = cmd_q.colour;
            // 2x2 buffer-pixel cells
            video_pkg::PAT_CHECKER:
                wr_data = (bx[1] ^ by[1]) ? video_pkg::pixel_t'(~cmd_q.colour) : cmd_q.colour;
            video_pkg::PAT_GRADIENT:
                wr_data = '{red: 4'(bx), green: 4'(by), blue: cmd_q.colour.blue};
            default:
                wr_data = on_edge ? cmd_q.colour : video_pkg::PIXEL_BLACK;
        endcase
    end

    assign wr_en      = (state == ST_DRAW);
    assign wr_addr    = ADDR_W'(by * BUF_WIDTH + bx);
    assign frame_done = (state == ST_DONE);

    a_addr_range: assert property (
        @(posedge clk_display) disable iff (!rstn_display)
        wr_en |-> (int'(wr_addr) < DEPTH)
    );

endmodule

/* buffer_swap.sv */
`timescale 1ns/1ps

module buffer_swap (
    input  logic              clk_display,
    input  logic              rstn_display,
    input  logic              vsync,
    input  logic              frame_done,
    input  logic              wr_en_in,
    input  video_pkg::pixel_t rd_data_a,
    input  video_pkg::pixel_t rd_data_b,
    output logic              front_sel,
    output logic              draw_start,
    output logic              draw_ack,
    output logic              wr_en_a,
    output logic              wr_en_b,
    output video_pkg::pixel_t rd_data
);

    logic vsync_d;
    logic rst_done;
    logic swap_req;

    ////////////////////////////////////////////////////////////////////////////
    // Swap control

    // Start of vertical sync while the back buffer is finished
    assign swap_req = vsync_d && !vsync && frame_done;
    assign draw_ack = swap_req;

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            vsync_d    <= 1'b1;
            rst_done   <= 1'b0;
            front_sel  <= 1'b0;
            draw_start <= 1'b0;
        end else begin
            vsync_d  <= vsync;
            rst_done <= 1'b1;
            // One pass after reset and one per swap
            draw_start <= !rst_done || swap_req;
            if (swap_req) begin
                front_sel <= !front_sel;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Buffer routing

    // Front is A while front_sel is low
    assign wr_en_a = wr_en_in && front_sel;
    assign wr_en_b = wr_en_in && !front_sel;
    assign rd_data = front_sel ? rd_data_b : rd_data_a;

    // The buffer put on screen never has a pass still writing into it
    a_front_no_write: assert property (
        @(posedge clk_display) disable iff (!rstn_display)
        swap_req |-> !wr_en_in
    );

endmodule

/* frame_top.sv */
`timescale 1ns/1ps

module frame_top #(
    parameter int BUF_WIDTH  = 16,
    parameter int BUF_HEIGHT = 12,
    parameter int SCALE_LOG2 = 1,
    parameter int H_FRONT    = 2,
    parameter int H_SYNC     = 4,
    parameter int H_BACK     = 2,
    parameter int V_FRONT    = 1,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 1
) (
    input  logic                 clk_display,
    input  logic                 rstn_display,
    input  video_pkg::draw_cmd_t draw_cmd,
    output video_pkg::vga_out_t  vga
);

    localparam int DEPTH  = BUF_WIDTH * BUF_HEIGHT;
    localparam int ADDR_W = $clog2(DEPTH);

    logic              wr_en;
    logic              wr_en_a;
    logic              wr_en_b;
    logic [ADDR_W-1:0] wr_addr;
    video_pkg::pixel_t wr_data;
    logic [ADDR_W-1:0] rd_addr;
    video_pkg::pixel_t rd_data;
    video_pkg::pixel_t rd_data_a;
    video_pkg::pixel_t rd_data_b;
    logic              frame_done;
    logic              draw_start;
    logic              draw_ack;

    ////////////////////////////////////////////////////////////////////////////
    // Frame buffers

    frame_buffer #(.DEPTH(DEPTH)) fb_a_i (
        .clk_display(clk_display), .rstn_display(rstn_display), .wr_en(wr_en_a),
        .wr_addr(wr_addr), .wr_data(wr_data), .rd_addr(rd_addr), .rd_data(rd_data_a)
    );

    frame_buffer #(.DEPTH(DEPTH)) fb_b_i (
        .clk_display(clk_display), .rstn_display(rstn_display), .wr_en(wr_en_b),
        .wr_addr(wr_addr), .wr_data(wr_data), .rd_addr(rd_addr), .rd_data(rd_data_b)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Scan-out, drawing and swap control

    display_scanout #(
        .BUF_WIDTH(BUF_WIDTH), .BUF_HEIGHT(BUF_HEIGHT), .SCALE_LOG2(SCALE_LOG2),
        .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) display_scanout_i (
        .clk_display(clk_display), .rstn_display(rstn_display),
        .rd_data(rd_data), .rd_addr(rd_addr), .vga(vga)
    );

    pattern_drawer #(.BUF_WIDTH(BUF_WIDTH), .BUF_HEIGHT(BUF_HEIGHT)) pattern_drawer_i (
        .clk_display(clk_display), .rstn_display(rstn_display), .draw_cmd(draw_cmd),
        .draw_start(draw_start), .draw_ack(draw_ack), .wr_en(wr_en),
        .wr_addr(wr_addr), .wr_data(wr_data), .frame_done(frame_done)
    );

    buffer_swap buffer_swap_i (
        .clk_display(clk_display), .rstn_display(rstn_display), .vsync(vga.vsync),
        .frame_done(frame_done), .wr_en_in(wr_en), .rd_data_a(rd_data_a),
        .rd_data_b(rd_data_b), .front_sel(), .draw_start(draw_start),
        .draw_ack(draw_ack), .wr_en_a(wr_en_a), .wr_en_b(wr_en_b), .rd_data(rd_data)
    );

endmodule

/* tb_frame_top.sv */
`timescale 1ns/1ps

module tb_frame_top;

    localparam int BUF_WIDTH    = 16;
    localparam int BUF_HEIGHT   = 12;
    localparam int SCALE_LOG2   = 1;
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 4;
    localparam int H_BACK       = 2;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 1;
    localparam int H_ACTIVE     = BUF_WIDTH << SCALE_LOG2;
    localparam int V_ACTIVE     = BUF_HEIGHT << SCALE_LOG2;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 2;

    logic                 clk_display = 1'b0;
    logic                 rstn_display;
    video_pkg::draw_cmd_t draw_cmd;
    video_pkg::vga_out_t  vga;

    video_pkg::draw_cmd_t cmd_list[$];
    int                   wait_list[$];
    video_pkg::draw_cmd_t exp_cmd;
    logic                 trace_ready = 1'b0;
    logic                 check_en = 1'b0;
    int                   n_checked = 0;

    // Scan position rebuilt from the syncs
    int   x = 0;
    int   y = 0;
    int   cyc = 0;
    int   hfall_cyc = 0;
    int   vfall_cyc = 0;
    logic x_ok = 1'b0;
    logic y_ok = 1'b0;
    logic h_seen = 1'b0;
    logic v_seen = 1'b0;
    logic hs_q = 1'b1;
    logic vs_q = 1'b1;

    frame_top #(
        .BUF_WIDTH(BUF_WIDTH), .BUF_HEIGHT(BUF_HEIGHT), .SCALE_LOG2(SCALE_LOG2),
        .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) frame_top_i (
        .clk_display(clk_display), .rstn_display(rstn_display),
        .draw_cmd(draw_cmd), .vga(vga)
    );

    always #(CLK_PERIOD / 2) clk_display = !clk_display;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and compare tasks

    function automatic video_pkg::pixel_t expected_pixel(video_pkg::draw_cmd_t cmd,
                                                         int px, int py);
        int                bx;
        int                by;
        video_pkg::pixel_t res;
        bx = px >> SCALE_LOG2;
        by = py >> SCALE_LOG2;
        case (cmd.pattern)
            video_pkg::PAT_SOLID:    res = cmd.colour;
            video_pkg::PAT_CHECKER:  res = (((bx >> 1) ^ (by >> 1)) & 1) ?
                                           video_pkg::pixel_t'(~cmd.colour) : cmd.colour;
            video_pkg::PAT_GRADIENT: res = '{red: 4'(bx), green: 4'(by),
                                             blue: cmd.colour.blue};
            default: begin
                if (bx == 0 || bx == BUF_WIDTH - 1 || by == 0 || by == BUF_HEIGHT - 1) begin
                    res = cmd.colour;
                end else begin
                    res = video_pkg::PIXEL_BLACK;
                end
            end
        endcase
        return res;
    endfunction

    task automatic check_pixel(video_pkg::pixel_t got, video_pkg::pixel_t exp, int px, int py);
        if (got !== exp) begin
            $display("error at %0t ns: vga.colour at (%0d,%0d) got %h expected %h",
                     $time, px, py, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic check_count(int got, int exp, string name);
        if (got !== exp) begin
            $display("error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic check_reset_state();
        check_count(int'(vga.hsync), 1, "vga.hsync");
        check_count(int'(vga.vsync), 1, "vga.vsync");
        check_pixel(vga.colour, video_pkg::PIXEL_BLACK, -1, -1);
    endtask

    // Columns are pattern code, colour and frames to wait
    task automatic load_trace();
        int    fd;
        int    n;
        int    pat;
        int    col;
        int    frames;
        string line;
        fd = $fopen("frame_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file frame_trace.txt");
            $display("Done: errors found");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%d %h %d", pat, col, frames) == 3) begin
                    cmd_list.push_back('{pattern: video_pkg::pattern_e'(pat),
                                         colour: video_pkg::pixel_t'(col)});
                    wait_list.push_back(frames);
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sync timing, position tracking and pixel checks

    always @(negedge clk_display) begin
        if (rstn_display) begin
            cyc = cyc + 1;
            x = x + 1;
            if (vga.hsync && !hs_q && h_seen) begin
                check_count(cyc - hfall_cyc, H_SYNC, "hsync low width");
                x = -H_BACK;
                x_ok = 1'b1;
            end
            if (!vga.hsync && hs_q) begin
                if (h_seen) begin
                    check_count(cyc - hfall_cyc, H_TOTAL, "line period");
                end
                hfall_cyc = cyc;
                h_seen = 1'b1;
            end
            if (x == 0) begin
                y = y + 1;
            end
            if (vga.vsync && !vs_q && v_seen) begin
                check_count(cyc - vfall_cyc, V_SYNC * H_TOTAL, "vsync low width");
                y = -V_BACK;
                y_ok = 1'b1;
            end
            if (!vga.vsync && vs_q) begin
                if (v_seen) begin
                    check_count(cyc - vfall_cyc, FRAME_CYCLES, "frame period");
                end
                vfall_cyc = cyc;
                v_seen = 1'b1;
            end
            hs_q = vga.hsync;
            vs_q = vga.vsync;
            // Blanking checked on every frame and the active window only in the checked frame
            if (x_ok && y_ok) begin
                if (x >= 0 && x < H_ACTIVE && y >= 0 && y < V_ACTIVE) begin
                    if (check_en) begin
                        check_pixel(vga.colour, expected_pixel(exp_cmd, x, y), x, y);
                        n_checked++;
                    end
                end else begin
                    check_pixel(vga.colour, video_pkg::PIXEL_BLACK, x, y);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    initial begin
        draw_cmd = '{pattern: video_pkg::PAT_SOLID, colour: video_pkg::PIXEL_BLACK};
        exp_cmd = draw_cmd;
        rstn_display = 1'b0;
        load_trace();
        trace_ready = 1'b1;
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk_display);
            check_reset_state();
        end
        @(posedge clk_display);
        #DRIVE_DELAY;
        rstn_display = 1'b1;
        // First output cycle after reset
        @(posedge clk_display);
        @(negedge clk_display);
        check_reset_state();
        foreach (cmd_list[i]) begin
            @(posedge clk_display);
            #DRIVE_DELAY;
            draw_cmd = cmd_list[i];
            exp_cmd = cmd_list[i];
            repeat (wait_list[i]) @(negedge vga.vsync);
            // Check one whole frame from the back porch to the next sync
            @(posedge vga.vsync);
            n_checked = 0;
            check_en = 1'b1;
            @(negedge vga.vsync);
            check_en = 1'b0;
            check_count(n_checked, H_ACTIVE * V_ACTIVE, "checked pixel count");
        end
        $display("Done: no errors");
        $finish;
    end

    // Watchdog
    initial begin
        longint limit_ns;
        wait (trace_ready);
        limit_ns = longint'(cmd_list.size()) * 5 * FRAME_CYCLES * CLK_PERIOD +
                   RESET_CYCLES * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Done: errors found");
        $fatal(1);
    end

endmodule

/* frame_trace.txt */
# pattern code (0 solid, 1 checker, 2 gradient, 3 border), colour as 12-bit rgb hex,
# frames to wait before the checked frame
0 f00 3
1 0a5 3
2 00c 3
3 fff 3
0 3c9 3
3 e21 3
1 777 3
2 00f 3

/* files.f */
video_pkg.sv
frame_buffer.sv
display_scanout.sv
pattern_drawer.sv
buffer_swap.sv
frame_top.sv
tb_frame_top.sv
